// File: verilog.f
logic/pifo_cfg_pkg.sv
logic/pifo_types_pkg.sv
logic/priority_encoder_log.sv
logic/pifo_locate.sv
logic/pifo_slot_array.sv
logic/pifo_top.sv
testbench/tb_clock_gen.sv
testbench/pifo_assert.sv
testbench/pifo_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pifo_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = ** FAIL **

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/pifo_tb.sv
// directed tests, queue model, LCG and value check for the PIFO queue
`timescale 1ns/1ps

module pifo_tb;

  localparam int num_slots = 16;
  localparam int timeout   = 8;
  localparam int pw        = pifo_cfg_pkg::prio_width;
  localparam int pt        = pifo_cfg_pkg::port_width;

  logic clk;
  logic rst;
  logic rst_req;

  pifo_types_pkg::push_req_t push;
  pifo_types_pkg::pop_req_t  pop;
  pifo_types_pkg::pop_rsp_t  pop_rsp;
  pifo_types_pkg::drop_rsp_t drop;

  // model contents with the head at index 0
  pifo_types_pkg::entry_t    model_q[$];
  logic [31:0]               lcg_state;
  pifo_types_pkg::pop_rsp_t  got_rsp;
  pifo_types_pkg::drop_rsp_t got_drop;

  tb_clock_gen #(
    .period_ns    (40),
    .reset_cycles (8)
  ) i_clk_gen (
    .rst_req (rst_req),
    .clk     (clk),
    .rst     (rst)
  );

  pifo_top #(
    .num_slots (num_slots)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .push    (push),
    .pop     (pop),
    .pop_rsp (pop_rsp),
    .drop    (drop)
  );

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "wait timed out");
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pifo_types_pkg::entry_t make_entry(input int prio, input int port,
                                                        input logic [31:0] data);
    pifo_types_pkg::entry_t e;
    e.prio = pw'(prio);
    e.port = pt'(port);
    e.data = data;
    return e;
  endfunction

  task automatic model_apply(
    input  logic                   do_push,
    input  pifo_types_pkg::entry_t e,
    input  logic                   do_pop,
    input  logic [pt-1:0]          port,
    output logic                   rsp_v,
    output pifo_types_pkg::entry_t rsp_e,
    output logic                   drop_v,
    output pifo_types_pkg::entry_t drop_e
  );
    int hit;
    int pos;
    rsp_v  = 1'b0;
    rsp_e  = '0;
    drop_v = 1'b0;
    drop_e = '0;
    // pop sees the contents from before the push
    if (do_pop) begin
      hit = -1;
      for (int i = model_q.size() - 1; i >= 0; i--) begin
        if (model_q[i].port == port)
          hit = i;
      end
      if (hit >= 0) begin
        rsp_v = 1'b1;
        rsp_e = model_q[hit];
        model_q.delete(hit);
      end
    end
    if (do_push) begin
      // behind every equal priority
      pos = model_q.size();
      for (int i = model_q.size() - 1; i >= 0; i--) begin
        if (model_q[i].prio > e.prio)
          pos = i;
      end
      model_q.insert(pos, e);
      if (model_q.size() > num_slots) begin
        drop_v = 1'b1;
        drop_e = model_q[num_slots];
        model_q.delete(num_slots);
      end
    end
  endtask

  // one strobe and a compare of the response with the model
  task automatic step(input logic do_push, input pifo_types_pkg::entry_t e,
                      input logic do_pop, input logic [pt-1:0] port);
    logic                   exp_rsp_v;
    logic                   exp_drop_v;
    pifo_types_pkg::entry_t exp_rsp_e;
    pifo_types_pkg::entry_t exp_drop_e;
    int                     n;
    model_apply(do_push, e, do_pop, port, exp_rsp_v, exp_rsp_e, exp_drop_v, exp_drop_e);
    push.valid = do_push;
    push.entry = e;
    pop.valid  = do_pop;
    pop.port   = port;
    @(negedge clk);
    push = '0;
    pop  = '0;
    n = 1;
    while ((exp_rsp_v || exp_drop_v) && !pop_rsp.valid && !drop.valid) begin
      if (n >= timeout)
        report_timeout("a pop or drop response");
      @(negedge clk);
      n++;
    end
    check("response latency", 64'(n), 64'd1);
    check("pop_rsp.valid", 64'(pop_rsp.valid), 64'(exp_rsp_v));
    if (exp_rsp_v)
      check("pop_rsp.entry", 64'(pop_rsp.entry), 64'(exp_rsp_e));
    check("drop.valid", 64'(drop.valid), 64'(exp_drop_v));
    if (exp_drop_v)
      check("drop.entry", 64'(drop.entry), 64'(exp_drop_e));
    got_rsp  = pop_rsp;
    got_drop = drop;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    @(negedge clk);
    while (rst !== 1'b0) begin
      if (n >= 4 * timeout)
        report_timeout("reset release");
      @(negedge clk);
      n++;
    end
  endtask

  task automatic apply_reset();
    int n;
    n = 0;
    rst_req = 1'b1;
    while (rst !== 1'b1) begin
      if (n >= timeout)
        report_timeout("reset assertion");
      @(negedge clk);
      n++;
    end
    rst_req = 1'b0;
    wait_reset_release();
    model_q.delete();
  endtask

  task automatic drain_queue();
    while (model_q.size() > 0)
      step(1'b0, '0, 1'b1, model_q[0].port);
  endtask

  task automatic test_sorted_order();
    logic [31:0] exp_data [5];
    exp_data = '{32'h0b, 32'h0e, 32'h0d, 32'h0a, 32'h0c};
    step(1'b1, make_entry(40, 3, 32'h0a), 1'b0, '0);
    step(1'b1, make_entry(10, 3, 32'h0b), 1'b0, '0);
    step(1'b1, make_entry(40, 3, 32'h0c), 1'b0, '0);
    step(1'b1, make_entry(25, 3, 32'h0d), 1'b0, '0);
    step(1'b1, make_entry(10, 3, 32'h0e), 1'b0, '0);
    for (int i = 0; i < 5; i++) begin
      step(1'b0, '0, 1'b1, pt'(3));
      check("pop_rsp.entry.data", 64'(got_rsp.entry.data), 64'(exp_data[i]));
    end
  endtask

  task automatic test_pop_by_port();
    step(1'b1, make_entry(50, 1, 32'ha1), 1'b0, '0);
    step(1'b1, make_entry(20, 2, 32'ha2), 1'b0, '0);
    step(1'b1, make_entry(30, 1, 32'ha3), 1'b0, '0);
    step(1'b1, make_entry(20, 5, 32'ha4), 1'b0, '0);
    step(1'b0, '0, 1'b1, pt'(1));
    check("pop_rsp.entry.data", 64'(got_rsp.entry.data), 64'h0a3);
    // no entry on port 7
    step(1'b0, '0, 1'b1, pt'(7));
    check("pop_rsp.valid", 64'(got_rsp.valid), 64'd0);
    drain_queue();
  endtask

  task automatic test_overflow_last();
    for (int i = 0; i < num_slots; i++)
      step(1'b1, make_entry(10 * (i + 1), i % 4, 32'h100 + i), 1'b0, '0);
    step(1'b1, make_entry(5, 2, 32'h200), 1'b0, '0);
    check("drop.entry.prio", 64'(got_drop.entry.prio), 64'd160);
  endtask

  task automatic test_overflow_incoming();
    step(1'b1, make_entry(1000, 1, 32'h300), 1'b0, '0);
    check("drop.entry.data", 64'(got_drop.entry.data), 64'h300);
  endtask

  task automatic test_push_pop_full();
    step(1'b1, make_entry(75, 0, 32'h400), 1'b1, pt'(3));
    check("pop_rsp.valid", 64'(got_rsp.valid), 64'd1);
    check("drop.valid", 64'(got_drop.valid), 64'd0);
    drain_queue();
  endtask

  task automatic test_random_stream();
    logic [31:0]            r;
    logic [pt-1:0]          port;
    pifo_types_pkg::entry_t e;
    for (int i = 0; i < 200; i++) begin
      if (i == 100) begin
        port = (model_q.size() > 0) ? model_q[0].port : '0;
        apply_reset();
        step(1'b0, '0, 1'b1, port);
        check("pop_rsp.valid", 64'(got_rsp.valid), 64'd0);
      end
      r = lcg_next();
      e = make_entry(int'(r[12:8]), int'(r[14:13]), lcg_next());
      // 0 and 1 push, 2 pop, 3 push and pop
      step(r[31:30] != 2'd2, e, r[31:30] >= 2'd2, pt'(r[16:15]));
    end
    drain_queue();
  endtask

  initial begin
    lcg_state = 32'hed1a_fbfd;
    rst_req   = 1'b0;
    push      = '0;
    pop       = '0;
    wait_reset_release();
    test_sorted_order();
    test_pop_by_port();
    test_overflow_last();
    test_overflow_incoming();
    test_push_pop_full();
    test_random_stream();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: testbench/pifo_assert.sv
// concurrent checks on count and response strobes, bound into the slot array
`timescale 1ns/1ps

module pifo_assert #(
  parameter int num_slots = 16
) (
  input logic                       clk,
  input logic                       rst,
  input pifo_types_pkg::push_req_t  push,
  input pifo_types_pkg::pop_req_t   pop,
  input logic                       pop_hit,
  input logic [$clog2(num_slots):0] count,
  input pifo_types_pkg::pop_rsp_t   pop_rsp,
  input pifo_types_pkg::drop_rsp_t  drop
);

  localparam int cnt_w = $clog2(num_slots) + 1;

  count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= cnt_w'(num_slots))
    else $error("occupancy count above the number of slots");

  // one response per hit a cycle later
  rsp_after_hit: assert property (@(posedge clk) disable iff (rst)
    pop_rsp.valid |-> $past(pop.valid && pop_hit))
    else $error("pop response without a pop hit in the previous cycle");

  drop_after_full_push: assert property (@(posedge clk) disable iff (rst)
    drop.valid |-> $past(push.valid && (count == cnt_w'(num_slots))))
    else $error("drop reported without a push on a full queue");

endmodule

bind pifo_slot_array pifo_assert #(
  .num_slots (num_slots)
) i_assert (
  .clk     (clk),
  .rst     (rst),
  .push    (push),
  .pop     (pop),
  .pop_hit (pop_hit),
  .count   (count),
  .pop_rsp (pop_rsp),
  .drop    (drop)
);

// File: testbench/tb_clock_gen.sv
// clock and synchronous reset source for the testbench
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 8
) (
  input  logic rst_req,
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // power-on reset and then one more reset per request edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    forever begin
      @(posedge rst_req);
      rst = 1'b1;
      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;
    end
  end

endmodule

// File: logic/pifo_top.sv
// top-level sorted PIFO queue joining the locator and the slot array
`timescale 1ns/1ps

module pifo_top #(
  parameter int num_slots = pifo_cfg_pkg::default_slots
) (
  input  logic                      clk,
  input  logic                      rst,
  input  pifo_types_pkg::push_req_t push,
  input  pifo_types_pkg::pop_req_t  pop,
  output pifo_types_pkg::pop_rsp_t  pop_rsp,
  output pifo_types_pkg::drop_rsp_t drop
);

  localparam int idx_w = $clog2(num_slots);

  pifo_types_pkg::entry_t [num_slots-1:0] entries;
  logic [idx_w:0]                         count;
  logic [idx_w:0]                         push_idx;
  logic [idx_w-1:0]                       pop_idx;
  logic                                   pop_hit;

  // indices come straight from the registered array
  pifo_locate #(
    .num_slots (num_slots)
  ) i_locate (
    .entries   (entries),
    .count     (count),
    .push_prio (push.entry.prio),
    .pop_port  (pop.port),
    .push_idx  (push_idx),
    .pop_idx   (pop_idx),
    .pop_hit   (pop_hit)
  );

  pifo_slot_array #(
    .num_slots (num_slots)
  ) i_slot_array (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .pop      (pop),
    .push_idx (push_idx),
    .pop_idx  (pop_idx),
    .pop_hit  (pop_hit),
    .entries  (entries),
    .count    (count),
    .pop_rsp  (pop_rsp),
    .drop     (drop)
  );

endmodule

// File: logic/pifo_slot_array.sv
// sorted entry storage with insert, remove, occupancy count and drop
`timescale 1ns/1ps

module pifo_slot_array #(
  parameter int num_slots = 16
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  pifo_types_pkg::push_req_t              push,
  input  pifo_types_pkg::pop_req_t               pop,
  input  logic [$clog2(num_slots):0]             push_idx,
  input  logic [$clog2(num_slots)-1:0]           pop_idx,
  input  logic                                   pop_hit,
  output pifo_types_pkg::entry_t [num_slots-1:0] entries,
  output logic [$clog2(num_slots):0]             count,
  output pifo_types_pkg::pop_rsp_t               pop_rsp,
  output pifo_types_pkg::drop_rsp_t              drop
);

  localparam int idx_w = $clog2(num_slots);
  localparam int cnt_w = idx_w + 1;

  typedef enum logic [1:0] {
    sel_hold,
    sel_new,
    sel_left,
    sel_right
  } slot_sel_e;

  pifo_types_pkg::entry_t [num_slots-1:0] slots;
  pifo_types_pkg::entry_t                 nxt [num_slots];
  slot_sel_e                              sel [num_slots];

  logic                   do_push;
  logic                   do_pop;
  logic                   full;
  logic                   rsp_valid;
  pifo_types_pkg::entry_t rsp_entry;
  logic                   drop_valid;
  pifo_types_pkg::entry_t drop_entry;

  assign do_push = push.valid;
  assign do_pop  = pop.valid && pop_hit;
  assign full    = (count == cnt_w'(num_slots));

  // per-slot move with the pop index taken against the contents before the push
  always_comb begin
    int pu;
    int po;
    pu = int'(push_idx);
    po = int'(pop_idx);
    for (int i = 0; i < num_slots; i++) begin
      sel[i] = sel_hold;
      if (do_push && do_pop) begin
        // only the slots between the two indices move
        if (pu <= po) begin
          if (i == pu)
            sel[i] = sel_new;
          else if (i > pu && i <= po)
            sel[i] = sel_left;
        end else begin
          if (i == pu - 1)
            sel[i] = sel_new;
          else if (i >= po && i < pu - 1)
            sel[i] = sel_right;
        end
      end else if (do_push) begin
        if (i == pu)
          sel[i] = sel_new;
        else if (i > pu)
          sel[i] = sel_left;
      end else if (do_pop) begin
        if (i >= po && i < num_slots - 1)
          sel[i] = sel_right;
      end
    end
  end

  for (genvar g = 0; g < num_slots; g++) begin : g_slot
    pifo_types_pkg::entry_t left_e;
    pifo_types_pkg::entry_t right_e;

    if (g > 0) begin : g_left
      assign left_e = slots[g-1];
    end else begin : g_no_left
      assign left_e = slots[g];
    end

    if (g < num_slots - 1) begin : g_right
      assign right_e = slots[g+1];
    end else begin : g_no_right
      assign right_e = slots[g];
    end

    always_comb begin
      case (sel[g])
        sel_new:   nxt[g] = push.entry;
        sel_left:  nxt[g] = left_e;
        sel_right: nxt[g] = right_e;
        default:   nxt[g] = slots[g];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_slots; i++) begin
      slots[i] <= nxt[i];
    end
  end

  // saturates at num_slots since overflow drops instead of growing
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (do_push && !do_pop && !full) begin
      count <= count + cnt_w'(1);
    end else if (do_pop && !do_push) begin
      count <= count - cnt_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid  <= 1'b0;
      drop_valid <= 1'b0;
    end else begin
      rsp_valid  <= do_pop;
      drop_valid <= do_push && !do_pop && full;
    end
  end

  always_ff @(posedge clk) begin
    rsp_entry <= slots[pop_idx];
    // incoming entry falls off itself when it sorts past the last slot
    if (push_idx == cnt_w'(num_slots))
      drop_entry <= push.entry;
    else
      drop_entry <= slots[num_slots-1];
  end

  assign entries       = slots;
  assign pop_rsp.valid = rsp_valid;
  assign pop_rsp.entry = rsp_entry;
  assign drop.valid    = drop_valid;
  assign drop.entry    = drop_entry;

endmodule

// File: logic/pifo_locate.sv
// combinational insertion and pop-match slot lookup over the stored entries
`timescale 1ns/1ps

module pifo_locate #(
  parameter int num_slots = 16
) (
  input  pifo_types_pkg::entry_t [num_slots-1:0]  entries,
  input  logic [$clog2(num_slots):0]              count,
  input  logic [pifo_cfg_pkg::prio_width-1:0]     push_prio,
  input  logic [pifo_cfg_pkg::port_width-1:0]     pop_port,
  output logic [$clog2(num_slots):0]              push_idx,
  output logic [$clog2(num_slots)-1:0]            pop_idx,
  output logic                                    pop_hit
);

  localparam int idx_w = $clog2(num_slots);
  localparam int cnt_w = idx_w + 1;

  logic [num_slots-1:0] ins_map;
  logic [num_slots-1:0] pop_map;
  logic [idx_w-1:0]     ins_enc;
  logic                 ins_found;

  always_comb begin
    for (int i = 0; i < num_slots; i++) begin
      // strictly greater so equal priorities keep arrival order
      ins_map[i] = (cnt_w'(i) == count) ||
                   ((cnt_w'(i) < count) && (entries[i].prio > push_prio));
      pop_map[i] = (cnt_w'(i) < count) && (entries[i].port == pop_port);
    end
  end

  priority_encoder_log #(
    .width (num_slots)
  ) i_ins_enc (
    .decode (ins_map),
    .encode (ins_enc),
    .valid  (ins_found)
  );

  priority_encoder_log #(
    .width (num_slots)
  ) i_pop_enc (
    .decode (pop_map),
    .encode (pop_idx),
    .valid  (pop_hit)
  );

  // nothing marked only when full so the new entry goes past the end
  assign push_idx = ins_found ? {1'b0, ins_enc} : count;

endmodule

// File: logic/priority_encoder_log.sv
// log-depth encoder that finds the lowest set bit of a bitmap
`timescale 1ns/1ps

module priority_encoder_log #(
  parameter int width = 16
) (
  input  logic [width-1:0]         decode,
  output logic [$clog2(width)-1:0] encode,
  output logic                     valid
);

  localparam int lw  = $clog2(width);
  localparam int pot = 1 << lw;

  // bitmap padded up to a power of two
  logic [pot-1:0] pad;

  always_comb begin
    pad = '0;
    pad[width-1:0] = decode;
  end

  // level l holds pot >> l nodes that each cover 2**l input bits
  for (genvar l = 0; l <= lw; l++) begin : g_lvl
    logic [(pot>>l)-1:0] v;
    logic [lw-1:0]       idx [pot>>l];

    if (l == 0) begin : g_leaf
      assign v = pad;
      for (genvar n = 0; n < pot; n++) begin : g_n
        assign idx[n] = '0;
      end
    end else begin : g_node
      // bit l-1 of the index says the hit came from the upper half
      localparam logic [lw-1:0] hi_bit = lw'(1) << (l - 1);
      for (genvar n = 0; n < (pot >> l); n++) begin : g_n
        assign v[n] = g_lvl[l-1].v[2*n] | g_lvl[l-1].v[2*n+1];
        assign idx[n] = g_lvl[l-1].v[2*n] ? g_lvl[l-1].idx[2*n]
                                          : (g_lvl[l-1].idx[2*n+1] | hi_bit);
      end
    end
  end

  assign valid  = g_lvl[lw].v[0];
  assign encode = g_lvl[lw].idx[0];

endmodule

// File: logic/pifo_types_pkg.sv
// struct types for stored entries and the push, pop and drop interfaces
package pifo_types_pkg;

  // one stored element with prio in the upper bits
  typedef struct packed {
    logic [pifo_cfg_pkg::prio_width-1:0] prio;
    logic [pifo_cfg_pkg::port_width-1:0] port;
    logic [pifo_cfg_pkg::data_width-1:0] data;
  } entry_t;

  // single-cycle push strobe
  typedef struct packed {
    logic   valid;
    entry_t entry;
  } push_req_t;

  // single-cycle pop strobe that selects by port
  typedef struct packed {
    logic                                valid;
    logic [pifo_cfg_pkg::port_width-1:0] port;
  } pop_req_t;

  // entry returned one cycle after a pop hit
  typedef struct packed {
    logic   valid;
    entry_t entry;
  } pop_rsp_t;

  // entry pushed out of a full queue
  typedef struct packed {
    logic   valid;
    entry_t entry;
  } drop_rsp_t;

endpackage

// File: logic/pifo_cfg_pkg.sv
// queue field widths and default depth
package pifo_cfg_pkg;

  // scheduling rank where a lower value leaves first
  localparam int prio_width = 16;

  // egress port number carried with each entry
  localparam int port_width = 4;

  // opaque payload word
  localparam int data_width = 32;

  // default queue depth as a power of two
  localparam int default_slots = 16;

endpackage
